// File: source/heapCfgPkg.sv
`default_nettype none

package heapCfgPkg;

    // key and depth sizing
    localparam int KeyWidth      = 16;
    localparam int DefaultLevels = 4;
    localparam int MaxLevels     = 10;   // bounds the address fields below

    typedef logic [KeyWidth-1:0] keyT;   // compared unsigned everywhere

    // node index inside one level, deepest level has 2**(MaxLevels-1) nodes
    typedef logic [MaxLevels-2:0] nodeAddrT;

    typedef logic [3:0] levelIdxT;       // 1 is the root level

endpackage

`default_nettype wire

// File: source/heapTypesPkg.sv
`default_nettype none

package heapTypesPkg;

    // offer from outside
    typedef struct packed {
        logic            valid;
        heapCfgPkg::keyT key;
    } insertReqT;

    // token moving one level down per cycle
    typedef struct packed {
        logic                 active;
        heapCfgPkg::keyT      key;
        heapCfgPkg::nodeAddrT addr;    // node in the receiving level
    } siftTokT;

    // both children of one parent node
    typedef struct packed {
        heapCfgPkg::keyT left;
        heapCfgPkg::keyT right;
    } childPairT;

    // one read-and-clear per cycle, seen by every level
    typedef struct packed {
        logic                 active;
        heapCfgPkg::levelIdxT level;
        heapCfgPkg::nodeAddrT addr;
    } dumpReqT;

    typedef struct packed {
        logic            valid;
        heapCfgPkg::keyT key;
    } dumpOutT;

endpackage

`default_nettype wire

// File: source/heapLevel.sv
`timescale 1ns/1ps
`default_nettype none

module heapLevel #(
    parameter int Levels     = heapCfgPkg::DefaultLevels,
    parameter int LevelIndex = 1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  heapTypesPkg::siftTokT   tokIn,
    input  heapTypesPkg::childPairT childIn,
    input  heapCfgPkg::nodeAddrT    childAddr,
    input  heapTypesPkg::dumpReqT   dumpReq,
    output heapTypesPkg::siftTokT   tokOut,
    output heapTypesPkg::childPairT childOut,
    output heapCfgPkg::keyT         dumpKey,
    output logic                   busy
);
    import heapCfgPkg::*;

    localparam bit IsLast    = (LevelIndex == Levels);
    localparam int BankDepth = (LevelIndex > 1) ? 2 ** (LevelIndex - 2) : 1;
    localparam int IdxW      = (LevelIndex > 2) ? LevelIndex - 2 : 1;

    keyT      minChild;
    keyT      writeKey;
    logic     goRight;
    logic     takeChild;
    logic     dumpHit;
    logic     tokActive;
    keyT      tokKey;
    nodeAddrT tokAddr;

    ////////////////////////////////////////
    // sift compare
    ////////////////////////////////////////

    assign goRight   = childIn.right < childIn.left;   // left wins ties
    assign minChild  = goRight ? childIn.right : childIn.left;
    assign takeChild = !IsLast && (minChild < tokIn.key);  // deepest level keeps the key
    assign writeKey  = takeChild ? minChild : tokIn.key;

    assign busy    = tokIn.active;
    assign dumpHit = dumpReq.active && (dumpReq.level == levelIdxT'(LevelIndex));

    // token for the next level, held one cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tokActive <= 1'b0;
        end
        else
        begin
            tokActive <= tokIn.active && takeChild;
        end
    end

    always_ff @(posedge clk)
    begin
        tokKey  <= tokIn.key;
        tokAddr <= {tokIn.addr[MaxLevels-3:0], goRight};   // 2a or 2a+1
    end

    assign tokOut = '{active: tokActive, key: tokKey, addr: tokAddr};

    ////////////////////////////////////////
    // node storage
    ////////////////////////////////////////

    generate
        if (LevelIndex == 1)
        begin : gRoot
            keyT rootNode;

            always_ff @(posedge clk)
            begin
                if (dumpHit)
                begin
                    rootNode <= '0;
                end
                else if (tokIn.active)
                begin
                    rootNode <= writeKey;
                end
            end

            // root has no parent, its key goes to the sequencer as left
            assign childOut = '{left: rootNode, right: '0};
            assign dumpKey  = rootNode;
        end
        else
        begin : gBanks
            keyT             leftBank [BankDepth];    // even nodes
            keyT             rightBank [BankDepth];   // odd nodes
            logic [IdxW-1:0] ownIdx;
            logic [IdxW-1:0] dumpIdx;
            logic [IdxW-1:0] readIdx;

            assign ownIdx  = tokIn.addr[IdxW:1];
            assign dumpIdx = dumpReq.addr[IdxW:1];
            assign readIdx = childAddr[IdxW-1:0];   // parent address picks the pair

            always_ff @(posedge clk)
            begin
                if (dumpHit)
                begin
                    if (dumpReq.addr[0])
                    begin
                        rightBank[dumpIdx] <= '0;
                    end
                    else
                    begin
                        leftBank[dumpIdx] <= '0;
                    end
                end
                else if (tokIn.active)
                begin
                    if (tokIn.addr[0])
                    begin
                        rightBank[ownIdx] <= writeKey;
                    end
                    else
                    begin
                        leftBank[ownIdx] <= writeKey;
                    end
                end
            end

            assign childOut = '{left: leftBank[readIdx], right: rightBank[readIdx]};
            assign dumpKey  = dumpReq.addr[0] ? rightBank[dumpIdx] : leftBank[dumpIdx];
        end
    endgenerate

    // dump waits for an idle heap, so sift and dump never share a cycle
    assert property (@(posedge clk) disable iff (rst)
        tokIn.active |-> !dumpReq.active);

endmodule

`default_nettype wire

// File: source/heapSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module heapSequencer #(
    parameter int Levels = heapCfgPkg::DefaultLevels
) (
    input  logic                   clk,
    input  logic                   rst,
    input  heapTypesPkg::insertReqT offer,
    input  logic                   dumpStart,
    input  heapCfgPkg::keyT         rootKey,
    input  logic [Levels-1:0]      levelBusy,
    input  heapCfgPkg::keyT         dumpKeys [Levels],
    output logic                   insertReady,
    output heapTypesPkg::siftTokT   rootTok,
    output heapTypesPkg::dumpReqT   dumpReq,
    output heapTypesPkg::dumpOutT   dumpOut,
    output logic                   dumpDone
);
    import heapCfgPkg::*;

    logic     phase;
    logic     clearing;      // reset walk over all nodes
    logic     dumping;
    logic     dumpPending;
    logic     lastSeen;
    logic     outValid;
    keyT      outKey;
    keyT      selKey;
    levelIdxT walkLevel;
    nodeAddrT walkAddr;
    logic     offerTaken;
    logic     levelEnd;
    logic     walkEnd;
    logic     startNow;

    ////////////////////////////////////////
    // admission
    ////////////////////////////////////////

    assign insertReady = !phase && !clearing && !dumping && !dumpPending;
    assign offerTaken  = offer.valid && insertReady;

    // larger key replaces the root, sift starts at node 0
    assign rootTok = '{active: offerTaken && (offer.key > rootKey), key: offer.key, addr: '0};

    ////////////////////////////////////////
    // walk over levels and nodes
    ////////////////////////////////////////

    assign dumpReq  = '{active: clearing || dumping, level: walkLevel, addr: walkAddr};
    assign levelEnd = walkAddr == nodeAddrT'((32'd1 << (walkLevel - 1'b1)) - 32'd1);
    assign walkEnd  = levelEnd && (walkLevel == levelIdxT'(Levels));
    assign startNow = (dumpStart || dumpPending) && !clearing && !dumping && !(|levelBusy);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            phase       <= 1'b0;
            clearing    <= 1'b1;
            dumping     <= 1'b0;
            dumpPending <= 1'b0;
            walkLevel   <= levelIdxT'(1);
            walkAddr    <= '0;
        end
        else
        begin
            phase <= !phase;
            if (clearing || dumping)
            begin
                if (walkEnd)
                begin
                    clearing  <= 1'b0;
                    dumping   <= 1'b0;
                    walkLevel <= levelIdxT'(1);
                    walkAddr  <= '0;
                end
                else if (levelEnd)
                begin
                    walkLevel <= walkLevel + 1'b1;   // next level, leftmost node
                    walkAddr  <= '0;
                end
                else
                begin
                    walkAddr <= walkAddr + 1'b1;
                end
            end
            if (startNow)
            begin
                dumping     <= 1'b1;
                dumpPending <= 1'b0;
            end
            else if (dumpStart && !dumping)
            begin
                dumpPending <= 1'b1;   // held until all levels idle
            end
        end
    end

    // key of the addressed level
    always_comb
    begin
        selKey = '0;
        for (int n = 0; n < Levels; n++)
        begin
            if (walkLevel == levelIdxT'(n + 1))
            begin
                selKey = dumpKeys[n];
            end
        end
    end

    ////////////////////////////////////////
    // output register and finish pulse
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            outValid <= 1'b0;
            lastSeen <= 1'b0;
            dumpDone <= 1'b0;
        end
        else
        begin
            outValid <= dumping;             // clearing walk stays silent
            lastSeen <= dumping && walkEnd;
            dumpDone <= lastSeen;
        end
    end

    always_ff @(posedge clk)
    begin
        outKey <= selKey;
    end

    assign dumpOut = '{valid: outValid, key: outKey};

    // offers only while the walk counter is parked at the root
    assert property (@(posedge clk) disable iff (rst)
        offerTaken |-> (walkLevel == levelIdxT'(1)) && (walkAddr == '0));

    // finish follows the last output, never overlaps it
    assert property (@(posedge clk) disable iff (rst)
        dumpDone |-> $past(dumpOut.valid) && !dumpOut.valid);

endmodule

`default_nettype wire

// File: source/heapTop.sv
`timescale 1ns/1ps
`default_nettype none

module heapTop #(
    parameter int Levels = heapCfgPkg::DefaultLevels
) (
    input  logic                   clk,
    input  logic                   rst,
    input  heapTypesPkg::insertReqT offer,
    input  logic                   dumpStart,
    output logic                   insertReady,
    output heapTypesPkg::dumpOutT   dumpOut,
    output logic                   dumpDone
);
    import heapCfgPkg::*;
    import heapTypesPkg::*;

    siftTokT           tok [1:Levels+1];   // tok[n] sits in level n
    childPairT         child [1:Levels];   // pair served by level n
    keyT               dumpKeys [Levels];
    logic [Levels-1:0] levelBusy;
    dumpReqT           dumpReq;

    heapSequencer #(
        .Levels(Levels)
    ) sequencerInst (
        .clk(clk),
        .rst(rst),
        .offer(offer),
        .dumpStart(dumpStart),
        .rootKey(child[1].left),
        .levelBusy(levelBusy),
        .dumpKeys(dumpKeys),
        .insertReady(insertReady),
        .rootTok(tok[1]),
        .dumpReq(dumpReq),
        .dumpOut(dumpOut),
        .dumpDone(dumpDone)
    );

    generate
        for (genvar n = 1; n <= Levels; n++)
        begin : gLevel
            childPairT belowPair;
            nodeAddrT  parentAddr;

            if (n == Levels)
            begin : gDeepest
                assign belowPair = '0;   // no children below
            end
            else
            begin : gInner
                assign belowPair = child[n+1];
            end

            if (n == 1)
            begin : gRootAddr
                assign parentAddr = '0;
            end
            else
            begin : gParentAddr
                assign parentAddr = tok[n-1].addr;   // node being sifted above
            end

            heapLevel #(
                .Levels(Levels),
                .LevelIndex(n)
            ) levelInst (
                .clk(clk),
                .rst(rst),
                .tokIn(tok[n]),
                .childIn(belowPair),
                .childAddr(parentAddr),
                .dumpReq(dumpReq),
                .tokOut(tok[n+1]),
                .childOut(child[n]),
                .dumpKey(dumpKeys[n-1]),
                .busy(levelBusy[n-1])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: verification/heapChecker.sv
`timescale 1ns/1ps
`default_nettype none

module heapChecker #(
    parameter int Levels = heapCfgPkg::DefaultLevels
) (
    input logic                   clk,
    input logic                   rst,
    input heapTypesPkg::insertReqT offer,
    input logic                   insertReady,
    input heapTypesPkg::dumpOutT   dumpOut,
    input logic                   dumpDone
);
    import heapCfgPkg::*;

    localparam int Capacity = (2 ** Levels) - 1;

    typedef keyT keyQueueT [$];

    keyT      model [Capacity];   // multiset of kept keys
    keyQueueT got;                // outputs of the running dump
    string    testName;
    logic     wasRst;
    logic     doneBefore;
    logic     validBefore;
    int       valueErrors;
    int       orderErrors;
    int       protocolErrors;

    task setTest(input string name);
        testName = name;
    endtask

    task automatic clearModel();
        for (int i = 0; i < Capacity; i++)
        begin
            model[i] = '0;
        end
    endtask

    initial
    begin
        testName       = "reset_dump";
        wasRst         = 1'b0;
        doneBefore     = 1'b0;
        validBefore    = 1'b0;
        valueErrors    = 0;
        orderErrors    = 0;
        protocolErrors = 0;
        clearModel();
    end

    // insertion sort, ascending
    function automatic keyQueueT sortUp(input keyQueueT src);
        keyQueueT res;
        int       pos;
        for (int i = 0; i < src.size(); i++)
        begin
            pos = 0;
            while (pos < res.size() && res[pos] <= src[i])
            begin
                pos++;
            end
            res.insert(pos, src[i]);
        end
        return res;
    endfunction

    // larger key replaces the smallest one kept
    task automatic applyOffer(input keyT key);
        int minIdx;
        minIdx = 0;
        for (int i = 1; i < Capacity; i++)
        begin
            if (model[i] < model[minIdx])
            begin
                minIdx = i;
            end
        end
        if (key > model[minIdx])
        begin
            model[minIdx] = key;
        end
    endtask

    ////////////////////////////////////////
    // end of one dump
    ////////////////////////////////////////

    task automatic checkDump();
        keyQueueT expQ;
        keyQueueT expSorted;
        keyQueueT gotSorted;
        if (got.size() != Capacity)
        begin
            $display("CHECK FAILED %s: dump length expected %0d actual %0d",
                testName, Capacity, got.size());
            protocolErrors++;
        end
        else
        begin
            // position n (1-based) has its parent at n/2
            for (int n = 2; n <= Capacity; n++)
            begin
                if (got[n-1] < got[n/2-1])
                begin
                    $display("CHECK FAILED %s: position %0d expected at least %h actual %h",
                        testName, n, got[n/2-1], got[n-1]);
                    orderErrors++;
                end
            end
            for (int i = 0; i < Capacity; i++)
            begin
                expQ.push_back(model[i]);
            end
            expSorted = sortUp(expQ);
            gotSorted = sortUp(got);
            for (int i = 0; i < Capacity; i++)
            begin
                if (gotSorted[i] != expSorted[i])
                begin
                    $display("CHECK FAILED %s: sorted key %0d expected %h actual %h",
                        testName, i, expSorted[i], gotSorted[i]);
                    valueErrors++;
                end
            end
        end
        got.delete();
        clearModel();   // dump empties the heap
    endtask

    always @(negedge clk)
    begin
        if (rst)
        begin
            wasRst      = 1'b1;
            doneBefore  = 1'b0;
            validBefore = 1'b0;
        end
        else
        begin
            if (wasRst && (dumpOut.valid || dumpDone))
            begin
                $display("ERROR: dump outputs active right after reset");
                protocolErrors++;
            end
            wasRst = 1'b0;
            if (dumpOut.valid)
            begin
                if (got.size() != 0 && !validBefore)
                begin
                    $display("ERROR: dump outputs were not on consecutive cycles");
                    protocolErrors++;
                end
                got.push_back(dumpOut.key);
            end
            if (dumpDone)
            begin
                if (dumpOut.valid)
                begin
                    $display("ERROR: dumpDone came together with a valid output");
                    protocolErrors++;
                end
                if (doneBefore)
                begin
                    $display("ERROR: dumpDone stayed high for more than one cycle");
                    protocolErrors++;
                end
                else
                begin
                    if (!validBefore)
                    begin
                        $display("ERROR: dumpDone did not come right after the last output");
                        protocolErrors++;
                    end
                    checkDump();
                end
            end
            // an offer taken next to dumpDone lands in the emptied heap
            if (offer.valid && insertReady)
            begin
                applyOffer(offer.key);
            end
            doneBefore  = dumpDone;
            validBefore = dumpOut.valid;
        end
    end

    task automatic reportCounts(input int stimErrors, output int total);
        if (got.size() != 0)
        begin
            $display("ERROR: %0d dump outputs arrived without a dumpDone pulse", got.size());
            protocolErrors++;
        end
        total = valueErrors + orderErrors + protocolErrors + stimErrors;
        $display("errors: value %0d, heap order %0d, protocol %0d, stimulus %0d, total %0d",
            valueErrors, orderErrors, protocolErrors, stimErrors, total);
    endtask

endmodule

`default_nettype wire

// File: verification/heapTb.sv
`timescale 1ns/1ps
`default_nettype none

module heapTb;
    import heapCfgPkg::*;
    import heapTypesPkg::*;

    localparam int Levels     = DefaultLevels;
    localparam int Capacity   = (2 ** Levels) - 1;
    localparam int FillCount  = 40;
    localparam int ReadyLimit = 64;                      // cycles
    localparam int DoneLimit  = Capacity + Levels + 16;  // cycles

    typedef enum logic [1:0] {OpOffer, OpFill, OpDump} opT;

    typedef struct packed {
        opT         op;
        keyT        key;
        logic [2:0] testId;
    } stimRowT;

    logic      clk;
    logic      rst;
    insertReqT offer;
    logic      dumpStart;
    logic      insertReady;
    dumpOutT   dumpOut;
    logic      dumpDone;

    stimRowT     stim [$];
    logic [31:0] lfsrState;
    logic        tableReady;
    int          tbErrors;

    heapTop #(
        .Levels(Levels)
    ) dut_i (
        .clk(clk),
        .rst(rst),
        .offer(offer),
        .dumpStart(dumpStart),
        .insertReady(insertReady),
        .dumpOut(dumpOut),
        .dumpDone(dumpDone)
    );

    heapChecker #(
        .Levels(Levels)
    ) checkInst (
        .clk(clk),
        .rst(rst),
        .offer(offer),
        .insertReady(insertReady),
        .dumpOut(dumpOut),
        .dumpDone(dumpDone)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic string testName(input logic [2:0] id);
        case (id)
            3'd0: return "reset_dump";
            3'd1: return "five_keys";
            3'd2: return "lfsr_fill";
            3'd3: return "small_keys_dropped";
            3'd4: return "back_to_back_dump";
            default: return "unknown";
        endcase
    endfunction

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    task automatic drawKey(output keyT key);
        key = '0;
        for (int b = 0; b < KeyWidth; b++)
        begin
            key       = {key[KeyWidth-2:0], lfsrState[0]};   // one bit per step
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    task automatic addRow(input opT op, input keyT key, input logic [2:0] testId);
        stimRowT row;
        row.op     = op;
        row.key    = key;
        row.testId = testId;
        stim.push_back(row);
    endtask

    task automatic buildTable();
        addRow(OpDump, '0, 3'd0);          // empty heap gives zeros
        addRow(OpOffer, 16'h1234, 3'd1);
        addRow(OpOffer, 16'h0042, 3'd1);
        addRow(OpOffer, 16'hbeef, 3'd1);
        addRow(OpOffer, 16'h7000, 3'd1);
        addRow(OpOffer, 16'h0001, 3'd1);
        addRow(OpDump, '0, 3'd1);
        addRow(OpFill, '0, 3'd2);
        addRow(OpDump, '0, 3'd2);
        for (int i = 0; i < Capacity; i++)
        begin
            addRow(OpOffer, keyT'(16'hf000 + i * 16'h0111), 3'd3);
        end
        addRow(OpOffer, 16'h0005, 3'd3);
        addRow(OpOffer, 16'h1000, 3'd3);
        addRow(OpOffer, 16'hefff, 3'd3);
        addRow(OpOffer, 16'hf000, 3'd3);   // equal to root
        addRow(OpDump, '0, 3'd3);
        addRow(OpOffer, 16'h2222, 3'd4);
        addRow(OpOffer, 16'h3333, 3'd4);
        addRow(OpDump, '0, 3'd4);
        addRow(OpDump, '0, 3'd4);          // must come back all zeros
    endtask

    function automatic int rowCycles(input opT op);
        case (op)
            OpOffer: return 2;
            OpFill:  return 2 * FillCount;
            default: return Capacity + Levels + 4;
        endcase
    endfunction

    // all drive tasks start and end 2 ns after a rising edge
    task automatic waitReady(output logic ready);
        int waited;
        waited = 0;
        while (!insertReady && waited < ReadyLimit)
        begin
            @(posedge clk);
            #2;
            waited++;
        end
        ready = insertReady;
    endtask

    task automatic offerKey(input keyT key);
        logic ready;
        waitReady(ready);
        if (!ready)
        begin
            $display("ERROR: insertReady stayed low for %0d cycles, key %h not offered",
                ReadyLimit, key);
            tbErrors++;
        end
        else
        begin
            offer.valid = 1'b1;
            offer.key   = key;
            @(posedge clk);
            #2;
            offer.valid = 1'b0;
        end
    endtask

    task automatic runDump();
        int waited;
        dumpStart = 1'b1;
        @(posedge clk);
        #2;
        dumpStart = 1'b0;
        waited    = 0;
        while (!dumpDone && waited < DoneLimit)
        begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!dumpDone)
        begin
            $display("ERROR: no dumpDone within %0d cycles of dumpStart", DoneLimit);
            tbErrors++;
        end
        else
        begin
            @(posedge clk);   // dumpDone cycle still belongs to this test
            #2;
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial
    begin
        int         total;
        logic       ready;
        keyT        key;
        logic [2:0] lastId;
        rst        = 1'b1;
        offer      = '0;
        dumpStart  = 1'b0;
        tbErrors   = 0;
        lfsrState  = 32'ha5725f32;
        tableReady = 1'b0;
        buildTable();
        tableReady = 1'b1;
        lastId     = 3'd0;
        checkInst.setTest(testName(lastId));
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        waitReady(ready);   // clearing walk has to finish first
        if (!ready)
        begin
            $display("ERROR: insertReady did not rise after reset");
            tbErrors++;
        end
        for (int r = 0; r < stim.size(); r++)
        begin
            if (stim[r].testId != lastId)
            begin
                lastId = stim[r].testId;
                checkInst.setTest(testName(lastId));
            end
            case (stim[r].op)
                OpOffer: offerKey(stim[r].key);
                OpFill:
                begin
                    for (int k = 0; k < FillCount; k++)
                    begin
                        drawKey(key);
                        offerKey(key);
                    end
                end
                default: runDump();
            endcase
        end
        repeat (4) @(posedge clk);
        checkInst.reportCounts(tbErrors, total);
        if (total == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog, budget scales with the table
    initial
    begin
        int budget;
        int total;
        wait (tableReady);
        budget = 0;
        for (int r = 0; r < stim.size(); r++)
        begin
            budget += rowCycles(stim[r].op);
        end
        budget = 20 * budget + 200;
        repeat (budget) @(posedge clk);
        $display("TIMEOUT: the run did not finish within %0d cycles", budget);
        tbErrors++;
        checkInst.reportCounts(tbErrors, total);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: heapTop.f
source/heapCfgPkg.sv
source/heapTypesPkg.sv
source/heapLevel.sv
source/heapSequencer.sv
source/heapTop.sv
verification/heapChecker.sv
verification/heapTb.sv

// File: Makefile
# Verilator flow for the pipelined heap

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run heapTb, pass only on STATUS: PASS"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module heapTb -f heapTop.f -Mdir obj_dir
	@out=$$(./obj_dir/VheapTb); echo "$$out"; echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir
